//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_DBITS      32
`define CPU_REGNOBITS  4

// Reset vector and data memory depth in words
`define CPU_START_PC   32'h0000_0100
`define CPU_DMEM_WORDS 1024

// Memory-mapped I/O
`define CPU_ADDR_HEX   32'hFFFF_F000
`define CPU_ADDR_LEDR  32'hFFFF_F020
`define CPU_ADDR_KEY   32'hFFFF_F080
`define CPU_HEX_RESET  24'hFEDEAD
`define CPU_HEX_BITS   24
`define CPU_LEDR_BITS  10
`define CPU_KEY_BITS   4

`endif

//--- common/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  // Primary opcodes, inst[31:26]
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // Secondary opcodes for ALUR, inst[25:18]
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_EX   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic is_br;
    logic is_jal;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  // ------------------------------------------------------------
  // Pipeline registers
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`CPU_DBITS-1:0]     pc;
    op1_e                      op1;
    op2_e                      op2;
    ctrl_t                     ctrl;
    logic [`CPU_DBITS-1:0]     regval1;
    logic [`CPU_DBITS-1:0]     regval2;
    logic [`CPU_DBITS-1:0]     imm;     // Already sign extended
    logic [`CPU_REGNOBITS-1:0] wregno;
  } id_ex_t;

  typedef struct packed {
    ctrl_t                     ctrl;
    logic [`CPU_DBITS-1:0]     aluout;  // Also the memory address
    logic [`CPU_DBITS-1:0]     regval2; // Store data
    logic [`CPU_REGNOBITS-1:0] wregno;
  } ex_mem_t;

  typedef struct packed {
    logic                      wr_reg;
    logic [`CPU_REGNOBITS-1:0] wregno;
    logic [`CPU_DBITS-1:0]     value;
  } mem_wb_t;

endpackage

//--- core/fetch_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  mispredict,
  input  logic [`CPU_DBITS-1:0] pc_good,
  output logic [`CPU_DBITS-1:0] imem_addr,
  input  logic [`CPU_DBITS-1:0] imem_data,
  output logic [`CPU_DBITS-1:0] inst,
  output logic [`CPU_DBITS-1:0] inst_pc
);

  logic [`CPU_DBITS-1:0] pc;

  assign imem_addr = pc;

  // Predict fall-through, execute corrects us
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      pc <= `CPU_START_PC;
    else if (mispredict)
      pc <= pc_good;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  // Fetch/decode latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      inst    <= '0;
      inst_pc <= '0;
    end else if (mispredict) begin
      inst    <= '0;  // Bubble, decodes as a NOP
      inst_pc <= '0;
    end else if (!stall) begin
      inst    <= imem_data;
      inst_pc <= pc;
    end
  end

  // A JAL through a bad link value would break this
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- core/reg_file.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`CPU_REGNOBITS-1:0] rs,
  input  logic [`CPU_REGNOBITS-1:0] rt,
  output logic [`CPU_DBITS-1:0]     val_rs,
  output logic [`CPU_DBITS-1:0]     val_rt,
  input  cpu_pkg::mem_wb_t          wb
);

  localparam int nregs = 1 << `CPU_REGNOBITS;

  logic [`CPU_DBITS-1:0] regs [nregs];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < nregs; i++)
        regs[i] <= '0;
    end else if (wb.wr_reg) begin
      regs[wb.wregno] <= wb.value;
    end
  end

  // Write-through covers the writeback stage
  assign val_rs = (wb.wr_reg && wb.wregno == rs) ? wb.value : regs[rs];
  assign val_rt = (wb.wr_reg && wb.wregno == rt) ? wb.value : regs[rt];

endmodule

//--- core/decode_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`CPU_DBITS-1:0]     inst,
  input  logic [`CPU_DBITS-1:0]     inst_pc,
  input  logic                      stall,
  input  logic                      mispredict,
  input  cpu_pkg::fwd_sel_e         fwd_rs,
  input  cpu_pkg::fwd_sel_e         fwd_rt,
  input  logic [`CPU_DBITS-1:0]     ex_fwd,
  input  logic [`CPU_DBITS-1:0]     mem_fwd,
  input  cpu_pkg::mem_wb_t          wb,
  output logic [`CPU_REGNOBITS-1:0] rs,
  output logic [`CPU_REGNOBITS-1:0] rt,
  output logic                      uses_rt,
  output cpu_pkg::id_ex_t           id_ex
);

  cpu_pkg::op1_e             op1;
  cpu_pkg::op2_e             op2;
  cpu_pkg::ctrl_t            ctrl;
  logic [`CPU_REGNOBITS-1:0] rd;
  logic [`CPU_REGNOBITS-1:0] wregno;
  logic [`CPU_DBITS-1:0]     imm;
  logic [`CPU_DBITS-1:0]     val_rs;
  logic [`CPU_DBITS-1:0]     val_rt;

  // All-zero words are ALUR with an unused op2, so this keeps bubbles silent
  function automatic logic op2_valid(input logic [7:0] code);
    case (code)
      cpu_pkg::OP2_EQ, cpu_pkg::OP2_LT, cpu_pkg::OP2_LE, cpu_pkg::OP2_NE,
      cpu_pkg::OP2_ADD, cpu_pkg::OP2_AND, cpu_pkg::OP2_OR, cpu_pkg::OP2_XOR,
      cpu_pkg::OP2_SUB, cpu_pkg::OP2_NAND, cpu_pkg::OP2_NOR, cpu_pkg::OP2_NXOR,
      cpu_pkg::OP2_RSHF, cpu_pkg::OP2_LSHF: op2_valid = 1'b1;
      default:                              op2_valid = 1'b0;
    endcase
  endfunction

  function automatic logic [`CPU_DBITS-1:0] pick_opnd(
    input cpu_pkg::fwd_sel_e     sel,
    input logic [`CPU_DBITS-1:0] reg_val
  );
    case (sel)
      cpu_pkg::FWD_EX:  pick_opnd = ex_fwd;
      cpu_pkg::FWD_MEM: pick_opnd = mem_fwd;
      default:          pick_opnd = reg_val;
    endcase
  endfunction

  // Field extraction
  assign op1 = cpu_pkg::op1_e'(inst[31:26]);
  assign op2 = cpu_pkg::op2_e'(inst[25:18]);
  assign imm = {{(`CPU_DBITS-16){inst[23]}}, inst[23:8]};
  assign rd  = inst[11:8];
  assign rs  = inst[7:4];
  assign rt  = inst[3:0];

  reg_file i_reg_file (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .val_rs (val_rs),
    .val_rt (val_rt),
    .wb     (wb)
  );

  // ------------------------------------------------------------
  // Control decode
  // ------------------------------------------------------------
  always_comb begin
    ctrl    = '0;
    uses_rt = 1'b0;
    case (op1)
      cpu_pkg::OP1_ALUR: begin
        ctrl.wr_reg = op2_valid(inst[25:18]);
        uses_rt     = 1'b1;
      end
      cpu_pkg::OP1_BEQ, cpu_pkg::OP1_BLT, cpu_pkg::OP1_BLE, cpu_pkg::OP1_BNE: begin
        ctrl.is_br = 1'b1;
        uses_rt    = 1'b1;
      end
      cpu_pkg::OP1_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.wr_reg = 1'b1;  // Link into rt
      end
      cpu_pkg::OP1_LW: begin
        ctrl.rd_mem = 1'b1;
        ctrl.wr_reg = 1'b1;
      end
      cpu_pkg::OP1_SW: begin
        ctrl.wr_mem = 1'b1;
        uses_rt     = 1'b1;  // Store data
      end
      cpu_pkg::OP1_ADDI, cpu_pkg::OP1_ANDI, cpu_pkg::OP1_ORI, cpu_pkg::OP1_XORI:
        ctrl.wr_reg = 1'b1;
      default: ;
    endcase
  end

  assign wregno = (op1 == cpu_pkg::OP1_ALUR) ? rd : rt;

  // Decode/execute latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (mispredict || stall) begin
      id_ex <= '0;
    end else begin
      id_ex.pc      <= inst_pc;
      id_ex.op1     <= op1;
      id_ex.op2     <= op2;
      id_ex.ctrl    <= ctrl;
      id_ex.regval1 <= pick_opnd(fwd_rs, val_rs);
      id_ex.regval2 <= pick_opnd(fwd_rt, val_rt);
      id_ex.imm     <= imm;
      id_ex.wregno  <= wregno;
    end
  end

endmodule

//--- core/hazard_unit.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module hazard_unit (
  input  logic [`CPU_REGNOBITS-1:0] rs,
  input  logic [`CPU_REGNOBITS-1:0] rt,
  input  logic                      uses_rt,
  input  cpu_pkg::id_ex_t           id_ex,
  input  cpu_pkg::ex_mem_t          ex_mem,
  output cpu_pkg::fwd_sel_e         fwd_rs,
  output cpu_pkg::fwd_sel_e         fwd_rt,
  output logic                      stall
);

  // Youngest producer wins
  function automatic cpu_pkg::fwd_sel_e pick_src(input logic [`CPU_REGNOBITS-1:0] src);
    if (id_ex.ctrl.wr_reg && !id_ex.ctrl.rd_mem && id_ex.wregno == src)
      pick_src = cpu_pkg::FWD_EX;
    else if (ex_mem.ctrl.wr_reg && ex_mem.wregno == src)
      pick_src = cpu_pkg::FWD_MEM;
    else
      pick_src = cpu_pkg::FWD_NONE;
  endfunction

  assign fwd_rs = pick_src(rs);
  assign fwd_rt = pick_src(rt);

  // Load data only exists after the memory stage
  assign stall = id_ex.ctrl.rd_mem &&
                 (id_ex.wregno == rs || (uses_rt && id_ex.wregno == rt));

endmodule

//--- core/execute_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::id_ex_t       id_ex,
  output logic [`CPU_DBITS-1:0] alu_out,
  output logic                  mispredict,
  output logic [`CPU_DBITS-1:0] pc_good,
  output cpu_pkg::ex_mem_t      ex_mem
);

  logic [`CPU_DBITS-1:0] a;
  logic [`CPU_DBITS-1:0] b;
  logic [`CPU_DBITS-1:0] imm;
  logic [`CPU_DBITS-1:0] imm_x4;
  logic [`CPU_DBITS-1:0] pc_plus4;
  logic                  br_cond;

  assign a        = id_ex.regval1;
  assign b        = id_ex.regval2;
  assign imm      = id_ex.imm;
  assign imm_x4   = {imm[`CPU_DBITS-3:0], 2'b00};
  assign pc_plus4 = id_ex.pc + 32'd4;

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------
  always_comb begin
    case (id_ex.op1)
      cpu_pkg::OP1_ALUR: begin
        case (id_ex.op2)
          cpu_pkg::OP2_EQ:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a == b};
          cpu_pkg::OP2_LT:   alu_out = {{(`CPU_DBITS-1){1'b0}}, $signed(a) < $signed(b)};
          cpu_pkg::OP2_LE:   alu_out = {{(`CPU_DBITS-1){1'b0}}, $signed(a) <= $signed(b)};
          cpu_pkg::OP2_NE:   alu_out = {{(`CPU_DBITS-1){1'b0}}, a != b};
          cpu_pkg::OP2_ADD:  alu_out = a + b;
          cpu_pkg::OP2_AND:  alu_out = a & b;
          cpu_pkg::OP2_OR:   alu_out = a | b;
          cpu_pkg::OP2_XOR:  alu_out = a ^ b;
          cpu_pkg::OP2_SUB:  alu_out = a - b;
          cpu_pkg::OP2_NAND: alu_out = ~(a & b);
          cpu_pkg::OP2_NOR:  alu_out = ~(a | b);
          cpu_pkg::OP2_NXOR: alu_out = ~(a ^ b);
          cpu_pkg::OP2_RSHF: alu_out = $signed(a) >>> b;  // Sign fills
          cpu_pkg::OP2_LSHF: alu_out = a << b;
          default:           alu_out = '0;
        endcase
      end
      cpu_pkg::OP1_LW, cpu_pkg::OP1_SW,
      cpu_pkg::OP1_ADDI: alu_out = a + imm;  // Address or sum
      cpu_pkg::OP1_ANDI: alu_out = a & imm;
      cpu_pkg::OP1_ORI:  alu_out = a | imm;
      cpu_pkg::OP1_XORI: alu_out = a ^ imm;
      cpu_pkg::OP1_JAL:  alu_out = pc_plus4;  // Link value
      default:           alu_out = '0;
    endcase
  end

  // Branch condition, signed compares
  always_comb begin
    case (id_ex.op1)
      cpu_pkg::OP1_BEQ: br_cond = (a == b);
      cpu_pkg::OP1_BLT: br_cond = ($signed(a) < $signed(b));
      cpu_pkg::OP1_BLE: br_cond = ($signed(a) <= $signed(b));
      cpu_pkg::OP1_BNE: br_cond = (a != b);
      default:          br_cond = 1'b0;
    endcase
  end

  // Fetch always guesses PC+4, so any taken control flow is a miss
  assign mispredict = id_ex.ctrl.is_jal || (id_ex.ctrl.is_br && br_cond);
  assign pc_good    = id_ex.ctrl.is_jal ? a + imm_x4 : pc_plus4 + imm_x4;

  // Execute/memory latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem.ctrl    <= id_ex.ctrl;
      ex_mem.aluout  <= alu_out;
      ex_mem.regval2 <= b;
      ex_mem.wregno  <= id_ex.wregno;
    end
  end

  // The redirect bubbles decode, so the next cycle cannot miss again
  a_mispredict_strobe: assert property (
    @(posedge clk) disable iff (reset) mispredict |=> !mispredict);

endmodule

//--- core/mem_stage.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module mem_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  cpu_pkg::ex_mem_t         ex_mem,
  input  logic [`CPU_KEY_BITS-1:0] key,
  output logic [`CPU_DBITS-1:0]    mem_fwd,
  output cpu_pkg::mem_wb_t         wb,
  output logic [`CPU_LEDR_BITS-1:0] ledr,
  output logic [`CPU_HEX_BITS-1:0] hex
);

  localparam int dmem_abits = $clog2(`CPU_DMEM_WORDS);

  logic [`CPU_DBITS-1:0] dmem [`CPU_DMEM_WORDS];
  logic [`CPU_DBITS-1:0] addr;
  logic [dmem_abits-1:0] word_idx;
  logic [`CPU_DBITS-1:0] rd_data;
  logic                  sel_hex;
  logic                  sel_ledr;
  logic                  sel_key;

  assign addr     = ex_mem.aluout;
  assign word_idx = addr[dmem_abits+1:2];  // Word addressed
  assign sel_hex  = (addr == `CPU_ADDR_HEX);
  assign sel_ledr = (addr == `CPU_ADDR_LEDR);
  assign sel_key  = (addr == `CPU_ADDR_KEY);

  assign rd_data = sel_key ? {{(`CPU_DBITS-`CPU_KEY_BITS){1'b0}}, key} : dmem[word_idx];
  assign mem_fwd = ex_mem.ctrl.rd_mem ? rd_data : ex_mem.aluout;

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.wr_mem && !sel_hex && !sel_ledr)
      dmem[word_idx] <= ex_mem.regval2;
  end

  // ------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
      hex  <= `CPU_HEX_RESET;
    end else if (ex_mem.ctrl.wr_mem) begin
      if (sel_ledr)
        ledr <= ex_mem.regval2[`CPU_LEDR_BITS-1:0];
      if (sel_hex)
        hex <= ex_mem.regval2[`CPU_HEX_BITS-1:0];
    end
  end

  // Memory/writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.wr_reg <= ex_mem.ctrl.wr_reg;
      wb.wregno <= ex_mem.wregno;
      wb.value  <= mem_fwd;
    end
  end

  a_no_key_store: assert property (
    @(posedge clk) disable iff (reset) ex_mem.ctrl.wr_mem |-> !sel_key);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_top (
  input  logic                      clk,
  input  logic                      reset,
  output logic [`CPU_DBITS-1:0]     imem_addr,
  input  logic [`CPU_DBITS-1:0]     imem_data,
  input  logic [`CPU_KEY_BITS-1:0]  key,
  output logic [`CPU_LEDR_BITS-1:0] ledr,
  output logic [`CPU_HEX_BITS-1:0]  hex
);

  // ------------------------------------------------------------
  // Stage interconnect
  // ------------------------------------------------------------
  logic [`CPU_DBITS-1:0]     inst;
  logic [`CPU_DBITS-1:0]     inst_pc;
  logic [`CPU_REGNOBITS-1:0] rs;
  logic [`CPU_REGNOBITS-1:0] rt;
  logic                      uses_rt;
  logic                      stall;
  logic                      mispredict;
  logic [`CPU_DBITS-1:0]     pc_good;
  logic [`CPU_DBITS-1:0]     alu_out;  // EX forward
  logic [`CPU_DBITS-1:0]     mem_fwd;  // MEM forward
  cpu_pkg::fwd_sel_e         fwd_rs;
  cpu_pkg::fwd_sel_e         fwd_rt;
  cpu_pkg::id_ex_t           id_ex;
  cpu_pkg::ex_mem_t          ex_mem;
  cpu_pkg::mem_wb_t          wb;

  fetch_stage i_fetch (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .mispredict (mispredict),
    .pc_good    (pc_good),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .inst       (inst),
    .inst_pc    (inst_pc)
  );

  decode_stage i_decode (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .stall      (stall),
    .mispredict (mispredict),
    .fwd_rs     (fwd_rs),
    .fwd_rt     (fwd_rt),
    .ex_fwd     (alu_out),
    .mem_fwd    (mem_fwd),
    .wb         (wb),
    .rs         (rs),
    .rt         (rt),
    .uses_rt    (uses_rt),
    .id_ex      (id_ex)
  );

  hazard_unit i_hazard (
    .rs      (rs),
    .rt      (rt),
    .uses_rt (uses_rt),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .fwd_rs  (fwd_rs),
    .fwd_rt  (fwd_rt),
    .stall   (stall)
  );

  execute_stage i_execute (
    .clk        (clk),
    .reset      (reset),
    .id_ex      (id_ex),
    .alu_out    (alu_out),
    .mispredict (mispredict),
    .pc_good    (pc_good),
    .ex_mem     (ex_mem)
  );

  mem_stage i_mem (
    .clk     (clk),
    .reset   (reset),
    .ex_mem  (ex_mem),
    .key     (key),
    .mem_fwd (mem_fwd),
    .wb      (wb),
    .ledr    (ledr),
    .hex     (hex)
  );

endmodule

//--- sim/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int num_cases = 6;
localparam int prog_len  = 32;  // Words per program, the rest reads as NOP

logic [`CPU_DBITS-1:0] prog [num_cases][prog_len];
test_case_t            cases [num_cases];

// ------------------------------------------------------------
// Programs, one block per case
// ------------------------------------------------------------
task automatic load_programs();
  for (int c = 0; c < num_cases; c++)
    for (int i = 0; i < prog_len; i++)
      prog[c][i] = '0;

  // Dependent ALU chain over every op2 code and the immediate ops
  prog[0][0]  = i_type(cpu_pkg::OP1_ADDI, 16'h0123, 0, 1);   // r1 = 0x123
  prog[0][1]  = i_type(cpu_pkg::OP1_ADDI, 16'hFFFB, 1, 2);   // r2 = 0x11E
  prog[0][2]  = r_type(cpu_pkg::OP2_ADD, 3, 1, 2);           // r3 = 0x241
  prog[0][3]  = r_type(cpu_pkg::OP2_SUB, 4, 3, 1);           // r4 = 0x11E
  prog[0][4]  = r_type(cpu_pkg::OP2_XOR, 5, 4, 3);           // r5 = 0x35F
  prog[0][5]  = r_type(cpu_pkg::OP2_AND, 6, 5, 3);           // r6 = 0x241
  prog[0][6]  = r_type(cpu_pkg::OP2_OR, 7, 6, 2);            // r7 = 0x35F
  prog[0][7]  = r_type(cpu_pkg::OP2_NAND, 8, 7, 1);          // r8 = 0xFFFFFEFC
  prog[0][8]  = r_type(cpu_pkg::OP2_NOR, 9, 8, 4);           // r9 = 1
  prog[0][9]  = r_type(cpu_pkg::OP2_NXOR, 10, 9, 7);         // r10 = 0xFFFFFCA1
  prog[0][10] = r_type(cpu_pkg::OP2_RSHF, 11, 10, 9);        // r11 = 0xFFFFFE50
  prog[0][11] = r_type(cpu_pkg::OP2_LSHF, 12, 11, 9);        // r12 = 0xFFFFFCA0
  prog[0][12] = r_type(cpu_pkg::OP2_LT, 13, 12, 1);          // Signed, so 1
  prog[0][13] = r_type(cpu_pkg::OP2_LE, 14, 13, 9);          // 1 <= 1
  prog[0][14] = r_type(cpu_pkg::OP2_NE, 15, 14, 2);
  prog[0][15] = r_type(cpu_pkg::OP2_EQ, 5, 15, 9);
  prog[0][16] = r_type(cpu_pkg::OP2_ADD, 6, 13, 14);
  prog[0][17] = r_type(cpu_pkg::OP2_ADD, 6, 6, 15);
  prog[0][18] = r_type(cpu_pkg::OP2_ADD, 6, 6, 5);           // r6 = 4, one per flag
  prog[0][19] = i_type(cpu_pkg::OP1_ANDI, 16'h0FF0, 12, 7);  // r7 = 0xCA0
  prog[0][20] = i_type(cpu_pkg::OP1_ORI, 16'h7000, 7, 7);    // r7 = 0x7CA0
  prog[0][21] = i_type(cpu_pkg::OP1_XORI, 16'h8001, 7, 7);   // r7 = 0xFFFFFCA1
  prog[0][22] = r_type(cpu_pkg::OP2_ADD, 7, 7, 6);           // r7 = 0xFFFFFCA5
  prog[0][23] = i_type(cpu_pkg::OP1_ADDI, 16'h0008, 0, 9);   // r9 = 8
  prog[0][24] = r_type(cpu_pkg::OP2_RSHF, 11, 11, 9);        // r11 = 0xFFFFFFFE
  prog[0][25] = r_type(cpu_pkg::OP2_XOR, 7, 7, 11);          // r7 = 0x35B
  prog[0][26] = i_type(cpu_pkg::OP1_SW, 16'hF000, 0, 7);     // HEX
  prog[0][27] = r_type(cpu_pkg::OP2_ADD, 8, 7, 3);           // r8 = 0x59C
  prog[0][28] = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 8);     // LEDR
  prog[0][29] = i_type(cpu_pkg::OP1_BEQ, 16'hFFFF, 0, 0);

  // Store, reload and use at once
  prog[1][0]  = i_type(cpu_pkg::OP1_ADDI, 16'h0ABC, 0, 1);
  prog[1][1]  = i_type(cpu_pkg::OP1_ORI, 16'h0040, 0, 2);    // Base address
  prog[1][2]  = i_type(cpu_pkg::OP1_SW, 16'h0004, 2, 1);     // mem[0x44] = 0xABC
  prog[1][3]  = i_type(cpu_pkg::OP1_LW, 16'h0004, 2, 3);
  prog[1][4]  = i_type(cpu_pkg::OP1_ADDI, 16'h0111, 3, 4);   // Load-use on rs
  prog[1][5]  = r_type(cpu_pkg::OP2_ADD, 5, 4, 3);           // r5 = 0x1689
  prog[1][6]  = i_type(cpu_pkg::OP1_SW, 16'hF000, 0, 5);
  prog[1][7]  = i_type(cpu_pkg::OP1_LW, 16'h0004, 2, 6);
  prog[1][8]  = r_type(cpu_pkg::OP2_SUB, 7, 4, 6);           // Load-use on rt
  prog[1][9]  = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 7);
  prog[1][10] = i_type(cpu_pkg::OP1_BEQ, 16'hFFFF, 0, 0);

  // Every branch taken and not taken, r9 collects one bit per survivor
  prog[2][0]  = i_type(cpu_pkg::OP1_ADDI, 16'h0005, 0, 1);   // r1 = 5
  prog[2][1]  = i_type(cpu_pkg::OP1_ADDI, 16'hFFFD, 0, 2);   // r2 = -3
  prog[2][2]  = i_type(cpu_pkg::OP1_BEQ, 16'h0002, 1, 1);    // Taken
  prog[2][3]  = i_type(cpu_pkg::OP1_ADDI, 16'h0200, 9, 9);   // Wrong path
  prog[2][4]  = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 1);     // Wrong path
  prog[2][5]  = i_type(cpu_pkg::OP1_ADDI, 16'h0001, 9, 9);
  prog[2][6]  = i_type(cpu_pkg::OP1_BEQ, 16'h0002, 1, 2);
  prog[2][7]  = i_type(cpu_pkg::OP1_ADDI, 16'h0002, 9, 9);
  prog[2][8]  = i_type(cpu_pkg::OP1_BLT, 16'h0002, 2, 1);    // -3 < 5, taken
  prog[2][9]  = i_type(cpu_pkg::OP1_ADDI, 16'h0200, 9, 9);
  prog[2][10] = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 1);
  prog[2][11] = i_type(cpu_pkg::OP1_ADDI, 16'h0004, 9, 9);
  prog[2][12] = i_type(cpu_pkg::OP1_BLT, 16'h0002, 1, 2);
  prog[2][13] = i_type(cpu_pkg::OP1_ADDI, 16'h0008, 9, 9);
  prog[2][14] = i_type(cpu_pkg::OP1_BLE, 16'h0002, 1, 1);    // Taken
  prog[2][15] = i_type(cpu_pkg::OP1_ADDI, 16'h0200, 9, 9);
  prog[2][16] = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 1);
  prog[2][17] = i_type(cpu_pkg::OP1_ADDI, 16'h0010, 9, 9);
  prog[2][18] = i_type(cpu_pkg::OP1_BLE, 16'h0002, 1, 2);
  prog[2][19] = i_type(cpu_pkg::OP1_ADDI, 16'h0020, 9, 9);
  prog[2][20] = i_type(cpu_pkg::OP1_BNE, 16'h0002, 1, 2);    // Taken
  prog[2][21] = i_type(cpu_pkg::OP1_ADDI, 16'h0200, 9, 9);
  prog[2][22] = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 1);
  prog[2][23] = i_type(cpu_pkg::OP1_ADDI, 16'h0040, 9, 9);
  prog[2][24] = i_type(cpu_pkg::OP1_BNE, 16'h0002, 1, 1);
  prog[2][25] = i_type(cpu_pkg::OP1_ADDI, 16'h0080, 9, 9);
  prog[2][26] = i_type(cpu_pkg::OP1_SW, 16'hF000, 0, 9);     // HEX, LEDR stays clear
  prog[2][27] = i_type(cpu_pkg::OP1_BEQ, 16'hFFFF, 0, 0);

  // Call to 0x120 with link in r15, return through r15
  prog[3][0]  = i_type(cpu_pkg::OP1_ADDI, 16'h0300, 0, 2);
  prog[3][1]  = i_type(cpu_pkg::OP1_ADDI, 16'h0050, 0, 14);
  prog[3][2]  = i_type(cpu_pkg::OP1_JAL, 16'h0048, 0, 15);   // r15 = 0x10C
  prog[3][3]  = r_type(cpu_pkg::OP2_ADD, 2, 2, 14);          // Return lands here
  prog[3][4]  = i_type(cpu_pkg::OP1_SW, 16'hF000, 0, 2);
  prog[3][5]  = i_type(cpu_pkg::OP1_BEQ, 16'hFFFF, 0, 0);
  prog[3][8]  = r_type(cpu_pkg::OP2_ADD, 2, 2, 15);          // r2 = 0x40C
  prog[3][9]  = i_type(cpu_pkg::OP1_JAL, 16'h0000, 15, 14);  // r14 = 0x128
  prog[3][10] = i_type(cpu_pkg::OP1_ADDI, 16'h0700, 2, 2);
  prog[3][11] = i_type(cpu_pkg::OP1_ADDI, 16'h0700, 2, 2);

  // KEY read copied to LEDR, run with two key values
  for (int c = 4; c < num_cases; c++) begin
    prog[c][0] = i_type(cpu_pkg::OP1_LW, 16'hF080, 0, 1);
    prog[c][1] = i_type(cpu_pkg::OP1_SW, 16'hF020, 0, 1);
    prog[c][2] = i_type(cpu_pkg::OP1_BEQ, 16'hFFFF, 0, 0);
  end

  // key, expected ledr, expected hex
  cases[0] = {4'h0, 10'h19C, 24'h00035B};
  cases[1] = {4'h0, 10'h111, 24'h001689};
  cases[2] = {4'h0, 10'h000, 24'h0000FF};
  cases[3] = {4'h0, 10'h000, 24'h000534};
  cases[4] = {4'hA, 10'h00A, `CPU_HEX_RESET};
  cases[5] = {4'h5, 10'h005, `CPU_HEX_RESET};
endtask

`endif

//--- sim/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpu_tb;

  typedef struct packed {
    logic [`CPU_KEY_BITS-1:0]  key;
    logic [`CPU_LEDR_BITS-1:0] ledr;
    logic [`CPU_HEX_BITS-1:0]  hex;
  } test_case_t;

  logic                      clk = 1'b0;
  logic                      reset;
  logic [`CPU_DBITS-1:0]     imem_addr;
  logic [`CPU_DBITS-1:0]     imem_data;
  logic [`CPU_KEY_BITS-1:0]  key;
  logic [`CPU_LEDR_BITS-1:0] ledr;
  logic [`CPU_HEX_BITS-1:0]  hex;
  int                        cur;     // Case being served
  int                        cycles;

  // ------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------
  function automatic logic [`CPU_DBITS-1:0] r_type(
    input cpu_pkg::op2_e op2,
    input logic [3:0]    rd,
    input logic [3:0]    rs,
    input logic [3:0]    rt
  );
    r_type = {cpu_pkg::OP1_ALUR, op2, 6'b000000, rd, rs, rt};
  endfunction

  function automatic logic [`CPU_DBITS-1:0] i_type(
    input cpu_pkg::op1_e op1,
    input logic [15:0]   imm,
    input logic [3:0]    rs,
    input logic [3:0]    rt
  );
    i_type = {op1, 2'b00, imm, rs, rt};
  endfunction

  `include "tb_programs.svh"

  localparam int timeout_limit = num_cases * 160 + 50;

  cpu_top i_cpu_top (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .key       (key),
    .ledr      (ledr),
    .hex       (hex)
  );

  always #5 clk = ~clk;

  // Word of the current program, NOP outside it
  function automatic logic [`CPU_DBITS-1:0] program_word(input logic [`CPU_DBITS-1:0] addr);
    logic [`CPU_DBITS-1:0] offset;
    offset = addr - `CPU_START_PC;
    if (offset[1:0] == 2'b00 && (offset >> 2) < prog_len)
      program_word = prog[cur][offset >> 2];
    else
      program_word = '0;
  endfunction

  always @(negedge clk) begin
    imem_data = program_word(imem_addr);
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic check_pc(input logic [`CPU_DBITS-1:0] got, input logic [`CPU_DBITS-1:0] exp,
                          input int c);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: case %0d imem_addr 0x%08h, expected 0x%08h",
               $time, c, got, exp);
      abort_run();
    end
  endtask

  task automatic check_ledr(input logic [`CPU_LEDR_BITS-1:0] got,
                            input logic [`CPU_LEDR_BITS-1:0] exp, input int c);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: case %0d ledr 0x%03h, expected 0x%03h",
               $time, c, got, exp);
      abort_run();
    end
  endtask

  task automatic check_hex(input logic [`CPU_HEX_BITS-1:0] got,
                           input logic [`CPU_HEX_BITS-1:0] exp, input int c);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: case %0d hex 0x%06h, expected 0x%06h",
               $time, c, got, exp);
      abort_run();
    end
  endtask

  // Guard against a run that never finishes
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_limit) begin
      $display("Timeout: the test cases did not finish within %0d cycles", timeout_limit);
      abort_run();
    end
  end

  initial begin
    reset     = 1'b1;
    key       = '0;
    imem_data = '0;
    cur       = 0;
    cycles    = 0;
    load_programs();
    for (int c = 0; c < num_cases; c++) begin
      @(negedge clk);
      reset = 1'b1;
      cur   = c;
      key   = cases[c].key;
      repeat (3) @(negedge clk);
      // Reset state before the program runs
      check_pc(imem_addr, `CPU_START_PC, c);
      check_ledr(ledr, '0, c);
      check_hex(hex, `CPU_HEX_RESET, c);
      reset = 1'b0;
      repeat (150) @(negedge clk);  // Long enough to reach the final self-branch
      check_ledr(ledr, cases[c].ledr, c);
      check_hex(hex, cases[c].hex, c);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+common
+incdir+sim
common/cpu_pkg.sv
core/fetch_stage.sv
core/reg_file.sv
core/decode_stage.sv
core/hazard_unit.sv
core/execute_stage.sv
core/mem_stage.sv
rtl/cpu_top.sv
sim/cpu_tb.sv
